/* Makefile */
TOP ?= tb_zhxpu
FILELIST ?= filelist.f
LOG ?= sim.log
OBJ_DIR ?= obj_dir
VERILATOR ?= verilator
VERILATOR_FLAGS ?= --binary --timing -Wno-fatal -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -x "Done: no errors" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* filelist.f */
logic/cpu_pkg.sv
logic/mem_bus_if.sv
logic/fetch_unit.sv
logic/decoder.sv
logic/reg_file.sv
logic/stage_reg.sv
logic/exe_unit.sv
logic/data_ram.sv
logic/zhxpu.sv
tests/tb_zhxpu.sv

/* logic/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_addr_t;

	// operations after decode, zero is a bubble
	typedef enum logic [3:0] {
		OP_NOP   = 4'd0,
		OP_ADDU  = 4'd1,
		OP_SUBU  = 4'd2,
		OP_AND   = 4'd3,
		OP_OR    = 4'd4,
		OP_ADDIU = 4'd5,
		OP_LI    = 4'd6,
		OP_LW    = 4'd7,
		OP_SW    = 4'd8,
		OP_B     = 4'd9,
		OP_BEQZ  = 4'd10
	} opcode_t;

	// instruction class in bits 15:11
	localparam logic [4:0] CLS_NOP   = 5'b00001;
	localparam logic [4:0] CLS_B     = 5'b00010;
	localparam logic [4:0] CLS_BEQZ  = 5'b00100;
	localparam logic [4:0] CLS_ADDIU = 5'b01001;
	localparam logic [4:0] CLS_LI    = 5'b01101;
	localparam logic [4:0] CLS_LW    = 5'b10011;
	localparam logic [4:0] CLS_SW    = 5'b11011;
	localparam logic [4:0] CLS_ALU   = 5'b11100;

	// function field in bits 1:0 of the ALU class, rz = rx op ry
	localparam logic [1:0] FN_AND  = 2'b00;
	localparam logic [1:0] FN_ADDU = 2'b01;
	localparam logic [1:0] FN_OR   = 2'b10;
	localparam logic [1:0] FN_SUBU = 2'b11;

	localparam word_t NOP_INSTR = 16'h0800;

	// memory sizes in words
	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;
	localparam int IMEM_AW = $clog2(IMEM_DEPTH);
	localparam int DMEM_AW = $clog2(DMEM_DEPTH);

	// data memory wait states
	localparam int MEM_WAIT = 2;
	localparam int MEM_CNT_W = $clog2(MEM_WAIT + 1);
	typedef logic [MEM_CNT_W-1:0] wait_cnt_t;
	localparam wait_cnt_t WAIT_LAST = wait_cnt_t'(MEM_WAIT);

	typedef struct packed {
		word_t pc;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		opcode_t opcode;
		word_t op_a;
		word_t op_b;
		word_t imm;
		reg_addr_t dst;
		logic reg_we;
		logic mem_rd;
		logic mem_wr;
	} id_exe_t;

endpackage

`default_nettype wire

/* logic/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram(
	input wire clk,
	input wire rst_n,
	mem_bus_if.slave mem
);
	cpu_pkg::word_t ram [cpu_pkg::DMEM_DEPTH];
	cpu_pkg::wait_cnt_t cnt;
	logic req;
	logic fire;

	assign req = mem.rd || mem.wr;
	// last wait state reached, access happens at this edge
	assign fire = req && !mem.done && cnt == cpu_pkg::WAIT_LAST;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
			mem.done <= 1'b0;
		end else begin
			mem.done <= fire;
			if (fire || !req) begin
				cnt <= '0;
			end else if (!mem.done) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			if (mem.wr) begin
				ram[mem.addr[cpu_pkg::DMEM_AW-1:0]] <= mem.wdata;
			end
			mem.rdata <= ram[mem.addr[cpu_pkg::DMEM_AW-1:0]];
		end
	end

endmodule

`default_nettype wire

/* logic/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder(
	input wire cpu_pkg::if_id_t dec_in,
	input wire cpu_pkg::word_t rdata1,
	input wire cpu_pkg::word_t rdata2,
	output cpu_pkg::reg_addr_t raddr1,
	output cpu_pkg::reg_addr_t raddr2,
	output logic set_pc,
	output cpu_pkg::word_t set_pc_addr,
	output cpu_pkg::id_exe_t dec_out
);
	logic [4:0] cls;
	logic [1:0] fn;
	cpu_pkg::reg_addr_t rx;
	cpu_pkg::reg_addr_t ry;
	cpu_pkg::reg_addr_t rz;
	cpu_pkg::word_t pc_next;
	cpu_pkg::word_t imm8_s;
	cpu_pkg::word_t imm8_z;
	cpu_pkg::word_t imm5_s;
	cpu_pkg::word_t imm11_s;

	assign cls = dec_in.instr[15:11];
	assign fn = dec_in.instr[1:0];
	assign rx = dec_in.instr[10:8];
	assign ry = dec_in.instr[7:5];
	assign rz = dec_in.instr[4:2];

	assign imm8_s = {{8{dec_in.instr[7]}}, dec_in.instr[7:0]};
	assign imm8_z = {8'h00, dec_in.instr[7:0]};
	assign imm5_s = {{11{dec_in.instr[4]}}, dec_in.instr[4:0]};
	assign imm11_s = {{5{dec_in.instr[10]}}, dec_in.instr[10:0]};

	// branch offsets count from the delay slot
	assign pc_next = dec_in.pc + 16'd1;

	// operands always come from rx and ry
	assign raddr1 = rx;
	assign raddr2 = ry;

	always_comb begin
		dec_out = '0;
		dec_out.opcode = cpu_pkg::OP_NOP;
		set_pc = 1'b0;
		set_pc_addr = pc_next;
		case (cls)
			cpu_pkg::CLS_ALU: begin
				case (fn)
					cpu_pkg::FN_ADDU: dec_out.opcode = cpu_pkg::OP_ADDU;
					cpu_pkg::FN_SUBU: dec_out.opcode = cpu_pkg::OP_SUBU;
					cpu_pkg::FN_AND: dec_out.opcode = cpu_pkg::OP_AND;
					default: dec_out.opcode = cpu_pkg::OP_OR;
				endcase
				dec_out.op_a = rdata1;
				dec_out.op_b = rdata2;
				dec_out.dst = rz;
				dec_out.reg_we = 1'b1;
			end
			cpu_pkg::CLS_ADDIU: begin
				dec_out.opcode = cpu_pkg::OP_ADDIU;
				dec_out.op_a = rdata1;
				dec_out.imm = imm8_s;
				dec_out.dst = rx;
				dec_out.reg_we = 1'b1;
			end
			cpu_pkg::CLS_LI: begin
				dec_out.opcode = cpu_pkg::OP_LI;
				dec_out.imm = imm8_z;
				dec_out.dst = rx;
				dec_out.reg_we = 1'b1;
			end
			cpu_pkg::CLS_LW: begin
				// ry <= mem[rx + imm5]
				dec_out.opcode = cpu_pkg::OP_LW;
				dec_out.op_a = rdata1;
				dec_out.imm = imm5_s;
				dec_out.dst = ry;
				dec_out.reg_we = 1'b1;
				dec_out.mem_rd = 1'b1;
			end
			cpu_pkg::CLS_SW: begin
				dec_out.opcode = cpu_pkg::OP_SW;
				dec_out.op_a = rdata1;
				dec_out.op_b = rdata2;
				dec_out.imm = imm5_s;
				dec_out.mem_wr = 1'b1;
			end
			cpu_pkg::CLS_B: begin
				dec_out.opcode = cpu_pkg::OP_B;
				set_pc = 1'b1;
				set_pc_addr = pc_next + imm11_s;
			end
			cpu_pkg::CLS_BEQZ: begin
				dec_out.opcode = cpu_pkg::OP_BEQZ;
				dec_out.op_a = rdata1;
				set_pc = (rdata1 == 16'h0000);
				set_pc_addr = pc_next + imm8_s;
			end
			// NOP and unknown classes stay a bubble
			default: begin
				dec_out.opcode = cpu_pkg::OP_NOP;
			end
		endcase
	end

endmodule

`default_nettype wire

/* logic/exe_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_unit(
	input wire clk,
	input wire rst_n,
	input wire cpu_pkg::id_exe_t exe_in,
	mem_bus_if.master mem,
	output logic hold,
	output logic exe_we,
	output cpu_pkg::reg_addr_t exe_addr,
	output cpu_pkg::word_t exe_value,
	output logic wb_we,
	output cpu_pkg::reg_addr_t wb_addr,
	output cpu_pkg::word_t wb_value
);
	cpu_pkg::word_t alu_res;

	always_comb begin
		case (exe_in.opcode)
			cpu_pkg::OP_ADDU: alu_res = exe_in.op_a + exe_in.op_b;
			cpu_pkg::OP_SUBU: alu_res = exe_in.op_a - exe_in.op_b;
			cpu_pkg::OP_AND: alu_res = exe_in.op_a & exe_in.op_b;
			cpu_pkg::OP_OR: alu_res = exe_in.op_a | exe_in.op_b;
			cpu_pkg::OP_LI: alu_res = exe_in.imm;
			// ADDIU, and the rx + imm5 address of LW and SW
			cpu_pkg::OP_ADDIU, cpu_pkg::OP_LW, cpu_pkg::OP_SW: alu_res = exe_in.op_a + exe_in.imm;
			default: alu_res = '0;
		endcase
	end

	// request lasts while the instruction sits in EXE
	assign mem.rd = exe_in.mem_rd;
	assign mem.wr = exe_in.mem_wr;
	assign mem.addr = alu_res;
	assign mem.wdata = exe_in.op_b;

	assign hold = (exe_in.mem_rd || exe_in.mem_wr) && !mem.done;

	// no bypass until the load data is back
	assign exe_we = exe_in.reg_we && !hold;
	assign exe_addr = exe_in.dst;
	assign exe_value = exe_in.mem_rd ? mem.rdata : alu_res;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_we <= 1'b0;
		end else begin
			wb_we <= exe_we;
		end
	end

	always_ff @(posedge clk) begin
		wb_addr <= exe_addr;
		wb_value <= exe_value;
	end

endmodule

`default_nettype wire

/* logic/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit(
	input wire clk,
	input wire rst_n,
	input wire run,
	input wire hold,
	input wire set_pc,
	input wire cpu_pkg::word_t set_pc_addr,
	input wire boot_we,
	input wire cpu_pkg::word_t boot_addr,
	input wire cpu_pkg::word_t boot_data,
	output cpu_pkg::if_id_t fetch
);
	cpu_pkg::word_t pc;
	cpu_pkg::word_t imem [cpu_pkg::IMEM_DEPTH];
	logic advance;

	assign advance = run && !hold;

	// boot port fills the instruction array
	always_ff @(posedge clk) begin
		if (boot_we) begin
			imem[boot_addr[cpu_pkg::IMEM_AW-1:0]] <= boot_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (advance) begin
			// branch from ID wins over the sequential step
			if (set_pc) begin
				pc <= set_pc_addr;
			end else begin
				pc <= pc + 16'd1;
			end
		end
	end

	always_comb begin
		fetch.pc = pc;
		if (advance) begin
			fetch.instr = imem[pc[cpu_pkg::IMEM_AW-1:0]];
		end else begin
			fetch.instr = cpu_pkg::NOP_INSTR;
		end
	end

endmodule

`default_nettype wire

/* logic/mem_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;
	// request held as a level until done
	logic rd;
	logic wr;
	cpu_pkg::word_t addr;
	cpu_pkg::word_t wdata;
	// reply, rdata valid with the done pulse
	cpu_pkg::word_t rdata;
	logic done;

	modport master(output rd, wr, addr, wdata, input rdata, done);
	modport slave(input rd, wr, addr, wdata, output rdata, done);
endinterface

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file(
	input wire clk,
	input wire rst_n,
	input wire cpu_pkg::reg_addr_t raddr1,
	input wire cpu_pkg::reg_addr_t raddr2,
	input wire wb_we,
	input wire cpu_pkg::reg_addr_t wb_addr,
	input wire cpu_pkg::word_t wb_value,
	input wire exe_we,
	input wire cpu_pkg::reg_addr_t exe_addr,
	input wire cpu_pkg::word_t exe_value,
	output cpu_pkg::word_t rdata1,
	output cpu_pkg::word_t rdata2
);
	cpu_pkg::word_t regs [8];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_we) begin
			regs[wb_addr] <= wb_value;
		end
	end

	// youngest result first, EXE before WB
	always_comb begin
		if (exe_we && exe_addr == raddr1) begin
			rdata1 = exe_value;
		end else if (wb_we && wb_addr == raddr1) begin
			rdata1 = wb_value;
		end else begin
			rdata1 = regs[raddr1];
		end
	end

	always_comb begin
		if (exe_we && exe_addr == raddr2) begin
			rdata2 = exe_value;
		end else if (wb_we && wb_addr == raddr2) begin
			rdata2 = wb_value;
		end else begin
			rdata2 = regs[raddr2];
		end
	end

endmodule

`default_nettype wire

/* logic/stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
	parameter type payload_t = cpu_pkg::word_t
)(
	input wire clk,
	input wire rst_n,
	input wire hold,
	input wire payload_t d,
	output payload_t q
);

	// all-zero payload is a bubble
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

/* logic/zhxpu.sv */
`timescale 1ns/1ps
`default_nettype none

module zhxpu(
	input wire clk,
	input wire rst_n,
	input wire boot_we,
	input wire cpu_pkg::word_t boot_addr,
	input wire cpu_pkg::word_t boot_data,
	input wire run,
	output cpu_pkg::reg_addr_t wb_addr,
	output cpu_pkg::word_t wb_value,
	output logic wb_we,
	output cpu_pkg::word_t pc
);
	logic hold;

	// IF stage
	logic set_pc;
	cpu_pkg::word_t set_pc_addr;
	cpu_pkg::if_id_t if_fetch;

	fetch_unit __fetch_unit(
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.hold(hold),
		.set_pc(set_pc),
		.set_pc_addr(set_pc_addr),
		.boot_we(boot_we),
		.boot_addr(boot_addr),
		.boot_data(boot_data),
		.fetch(if_fetch)
	);
	assign pc = if_fetch.pc;

	// IF/ID
	cpu_pkg::if_id_t id_in;

	stage_reg #(
		.payload_t(cpu_pkg::if_id_t)
	) __if_id(
		.clk(clk),
		.rst_n(rst_n),
		.hold(hold),
		.d(if_fetch),
		.q(id_in)
	);

	// ID stage
	cpu_pkg::reg_addr_t raddr1;
	cpu_pkg::reg_addr_t raddr2;
	cpu_pkg::word_t rdata1;
	cpu_pkg::word_t rdata2;
	cpu_pkg::id_exe_t id_out;

	decoder __decoder(
		.dec_in(id_in),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.set_pc(set_pc),
		.set_pc_addr(set_pc_addr),
		.dec_out(id_out)
	);

	logic exe_we;
	cpu_pkg::reg_addr_t exe_addr;
	cpu_pkg::word_t exe_value;

	reg_file __reg_file(
		.clk(clk),
		.rst_n(rst_n),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.wb_we(wb_we),
		.wb_addr(wb_addr),
		.wb_value(wb_value),
		.exe_we(exe_we),
		.exe_addr(exe_addr),
		.exe_value(exe_value),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	// ID/EXE
	cpu_pkg::id_exe_t exe_in;

	stage_reg #(
		.payload_t(cpu_pkg::id_exe_t)
	) __id_exe(
		.clk(clk),
		.rst_n(rst_n),
		.hold(hold),
		.d(id_out),
		.q(exe_in)
	);

	// EXE stage and data memory
	mem_bus_if dmem_bus();

	exe_unit __exe_unit(
		.clk(clk),
		.rst_n(rst_n),
		.exe_in(exe_in),
		.mem(dmem_bus.master),
		.hold(hold),
		.exe_we(exe_we),
		.exe_addr(exe_addr),
		.exe_value(exe_value),
		.wb_we(wb_we),
		.wb_addr(wb_addr),
		.wb_value(wb_value)
	);

	data_ram __data_ram(
		.clk(clk),
		.rst_n(rst_n),
		.mem(dmem_bus.slave)
	);

endmodule

`default_nettype wire

/* tests/tb_zhxpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_zhxpu;
	localparam string GOLDEN_FILE = "tests/zhxpu_golden.txt";
	localparam int RESET_CYCLES = 16;
	localparam int IDLE_CYCLES = 8;
	localparam int QUIET_CYCLES = 20;
	localparam int DRIVE_DELAY = 1;

	logic clk;
	logic rst_n;
	logic boot_we;
	cpu_pkg::word_t boot_addr;
	cpu_pkg::word_t boot_data;
	logic run;
	cpu_pkg::reg_addr_t wb_addr;
	cpu_pkg::word_t wb_value;
	logic wb_we;
	cpu_pkg::word_t pc;

	// program image and expected write-back sequence
	cpu_pkg::word_t boot_addrs[$];
	cpu_pkg::word_t boot_words[$];
	cpu_pkg::reg_addr_t exp_regs[$];
	cpu_pkg::word_t exp_values[$];

	int cycle = 0;
	int cycle_limit = 0;
	int n_writes = 0;

	zhxpu u_zhxpu(
		.clk(clk),
		.rst_n(rst_n),
		.boot_we(boot_we),
		.boot_addr(boot_addr),
		.boot_data(boot_data),
		.run(run),
		.wb_addr(wb_addr),
		.wb_value(wb_value),
		.wb_we(wb_we),
		.pc(pc)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	task automatic stop_on_error();
		$display("Done: errors found");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input cpu_pkg::word_t got,
			input cpu_pkg::word_t exp);
		if (got !== exp) begin
			$display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_reg(input string name, input cpu_pkg::reg_addr_t got,
			input cpu_pkg::reg_addr_t exp);
		if (got !== exp) begin
			$display("FAILED t=%0t %s: got r%0d expected r%0d", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED t=%0t %s: got %b expected %b", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	// B lines hold address and word and E lines hold register and value
	task automatic read_golden();
		int fd;
		int n;
		byte kind;
		logic [15:0] f1;
		logic [15:0] f2;
		string line;
		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0) begin
			$display("cannot open %s", GOLDEN_FILE);
			stop_on_error();
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1) begin
				kind = line.getc(0);
				n = $sscanf(line.substr(1, line.len() - 1), "%h %h", f1, f2);
				if (kind == "B" && n == 2) begin
					boot_addrs.push_back(f1);
					boot_words.push_back(f2);
				end else if (kind == "E" && n == 2) begin
					exp_regs.push_back(f1[2:0]);
					exp_values.push_back(f2);
				end
			end
		end
		$fclose(fd);
		if (boot_addrs.size() == 0 || exp_regs.size() == 0) begin
			$display("golden file has no boot words or no expected writes");
			stop_on_error();
		end
	endtask

	task automatic step_clock();
		@(posedge clk);
		#(DRIVE_DELAY);
	endtask

	task automatic boot_program();
		for (int i = 0; i < boot_addrs.size(); i++) begin
			step_clock();
			boot_we = 1'b1;
			boot_addr = boot_addrs[i];
			boot_data = boot_words[i];
		end
		step_clock();
		boot_we = 1'b0;
		boot_addr = '0;
		boot_data = '0;
	endtask

	// outputs are sampled mid-cycle
	always @(negedge clk) begin
		if (rst_n === 1'b1 && run === 1'b0) begin
			check_flag("wb_we", wb_we, 1'b0);
			check_word("pc", pc, 16'h0000);
		end else if (rst_n === 1'b1 && wb_we === 1'b1) begin
			if (n_writes >= exp_regs.size()) begin
				$display("unexpected write of %h to r%0d after the last expected write at t=%0t",
					wb_value, wb_addr, $time);
				stop_on_error();
			end else begin
				check_reg("wb_addr", wb_addr, exp_regs[n_writes]);
				check_word("wb_value", wb_value, exp_values[n_writes]);
				n_writes++;
			end
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle_limit > 0 && cycle >= cycle_limit) begin
			$display("timeout after %0d cycles with %0d of %0d writes seen",
				cycle, n_writes, exp_regs.size());
			stop_on_error();
		end
	end

	initial begin
		rst_n = 1'b0;
		boot_we = 1'b0;
		boot_addr = '0;
		boot_data = '0;
		run = 1'b0;
		read_golden();
		cycle_limit = RESET_CYCLES + boot_addrs.size() + 10 * exp_regs.size() + 100;

		repeat (RESET_CYCLES) begin
			@(posedge clk);
		end
		#(DRIVE_DELAY);
		rst_n = 1'b1;

		// pc and wb_we are watched by the monitor until run rises
		boot_program();
		repeat (IDLE_CYCLES) begin
			step_clock();
		end
		run = 1'b1;

		wait (n_writes == exp_regs.size());
		// program parks in a branch-to-self and writes nothing more
		repeat (QUIET_CYCLES) begin
			@(posedge clk);
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/zhxpu_golden.txt */
# B <imem address> <instruction word>, hex
# E <destination register> <written value>, hex, in program order
B 0000 69FF # li r1, 0xff
B 0001 6A80 # li r2, 0x80
B 0002 4AFF # addiu r2, -1
B 0003 E14D # addu r3 = r1 + r2
B 0004 E033 # subu r4 = r0 - r1
B 0005 E474 # and r5 = r4 & r3
B 0006 E55A # or r6 = r5 | r2
B 0007 E49D # addu r7 = r4 + r4
B 0008 6910 # li r1, 0x10
B 0009 D9E3 # sw r7, 3(r1)
B 000A 99A3 # lw r5, 3(r1)
B 000B E5B9 # addu r6 = r5 + r5
B 000C 6B05 # li r3, 5
B 000D D97F # sw r3, -1(r1)
B 000E 999F # lw r4, -1(r1)
B 000F 2002 # beqz r0, +2 taken
B 0010 6F11 # li r7, 0x11 delay slot
B 0011 6F99 # skipped
B 0012 2405 # beqz r4, +5 not taken
B 0013 4CFB # addiu r4, -5
B 0014 2403 # beqz r4, +3 taken
B 0015 4901 # addiu r1, 1 delay slot
B 0016 69EE # skipped
B 0017 6AEE # skipped
B 0018 1002 # b +2
B 0019 E1E9 # addu r2 = r1 + r7 delay slot
B 001A 6AEE # skipped
B 001B 17FF # b -1 to itself
B 001C 0800 # nop
E 1 00FF
E 2 0080
E 2 007F
E 3 017E
E 4 FF01
E 5 0100
E 6 017F
E 7 FE02
E 1 0010
E 5 FE02
E 6 FC04
E 3 0005
E 4 0005
E 7 0011
E 4 0000
E 1 0011
E 2 0022
